// File: include/gfx_macros.svh
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Display geometry in pixels and lines
`define H_ACTIVE 64
`define H_TOTAL 256
`define V_ACTIVE 12
`define V_TOTAL 16

`define NUM_LAYERS 2
`define LAYER_W 1	// Bits of a layer index

// One scanline buffer, four pixels per word
`define LINE_WORDS 32
`define LINE_TILES 5	// One more than visible for fine scroll
`define LINE_AW 5

`define POS_W 10	// Pixel and line counters
`define MEM_AW 16	// Tile memory word address
`define MEM_DW 16

`endif

// File: src/gfx_pkg.sv
`default_nettype none
`include "gfx_macros.svh"

package gfx_pkg;

	// Pixel position from the video timing generator
	typedef struct packed {
		logic line_start;
		logic frame_start;
		logic active;
		logic [`POS_W-1:0] x;
		logic [`POS_W-1:0] y;
		logic [`POS_W-1:0] render_y;	// Line being rendered ahead
	} vid_pos_t;

	// CPU register write strobe
	typedef struct packed {
		logic wr;
		logic [`LAYER_W-1:0] layer;
		logic [2:0] addr;
		logic [15:0] data;
	} reg_wr_t;

	// Tile memory read port
	typedef struct packed {
		logic req;
		logic [`MEM_AW-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic ack;	// Data valid in this cycle
		logic [`MEM_DW-1:0] data;
	} mem_rsp_t;

	typedef logic [7:0] color_t;	// Palette nibble, pixel nibble

endpackage

`default_nettype wire

// File: src/video_timing.sv
`default_nettype none
`include "gfx_macros.svh"

module video_timing (
	input wire CLK,
	input wire RSTb,
	output gfx_pkg::vid_pos_t pos
);
	localparam int X_LAST = `H_TOTAL - 1;
	localparam int Y_LAST = `V_TOTAL - 1;

	logic [`POS_W-1:0] x_nxt;
	logic [`POS_W-1:0] y_nxt;
	logic [`POS_W-1:0] ry_nxt;

	always_comb begin
		x_nxt = pos.x + 1'b1;
		y_nxt = pos.y;
		if (pos.x == X_LAST[`POS_W-1:0]) begin
			x_nxt = '0;
			y_nxt = (pos.y == Y_LAST[`POS_W-1:0]) ? '0 : pos.y + 1'b1;
		end
		ry_nxt = (y_nxt == Y_LAST[`POS_W-1:0]) ? '0 : y_nxt + 1'b1;
	end

	// Strobes decoded from the next count so they line up with x and y
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			// Park on the last position so the first frame starts right away
			pos.x <= X_LAST[`POS_W-1:0];
			pos.y <= Y_LAST[`POS_W-1:0];
			pos.render_y <= '0;
			pos.line_start <= 1'b0;
			pos.frame_start <= 1'b0;
			pos.active <= 1'b0;
		end else begin
			pos.x <= x_nxt;
			pos.y <= y_nxt;
			pos.render_y <= ry_nxt;
			pos.line_start <= (x_nxt == '0);
			pos.frame_start <= (x_nxt == '0) && (y_nxt == '0);
			pos.active <= (x_nxt < `H_ACTIVE) && (y_nxt < `V_ACTIVE);
		end
	end

endmodule

`default_nettype wire

// File: src/scanline_ram.sv
`default_nettype none
`include "gfx_macros.svh"

module scanline_ram (
	input wire CLK,
	input wire [`LINE_AW-1:0] rd_addr,
	output logic [15:0] rd_data,
	input wire [`LINE_AW-1:0] wr_addr,
	input wire [15:0] wr_data,
	input wire wr
);
	logic [15:0] mem [0:`LINE_WORDS-1];

	// Read returns the old word on a same-address write
	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: src/bg_layer.sv
`default_nettype none
`include "gfx_macros.svh"

module bg_layer #(
	parameter int LAYER_ID = 0
) (
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::reg_wr_t cpu_wr,
	input wire gfx_pkg::vid_pos_t pos,
	output gfx_pkg::mem_req_t mem_req,
	input wire gfx_pkg::mem_rsp_t mem_rsp,
	output gfx_pkg::color_t color
);
	localparam logic [`LAYER_W-1:0] MY_ID = LAYER_ID[`LAYER_W-1:0];
	localparam int LAST_TILE = `LINE_TILES - 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,	// Let a stale request finish first
		S_MAP,
		S_MAP_WAIT,
		S_TILE,
		S_TILE_WAIT
	} state_t;

	logic enable;
	logic [3:0] pal;
	logic [15:0] scroll_x;
	logic [15:0] scroll_y;
	logic [15:0] map_base;
	logic [15:0] set_base;

	state_t state;
	logic back_sel;	// Buffer being rendered
	logic [6:0] col;
	logic [2:0] tile_cnt;
	logic [1:0] word_cnt;
	logic [`LINE_AW-1:0] wr_ptr;
	logic [7:0] tile;

	logic swap;
	logic [15:0] vy;
	logic [16:0] map_idx;
	logic [15:0] tile_addr;
	logic fetch_wr;
	logic [15:0] fetch_data;

	logic [9:0] px;
	logic [`LINE_AW-1:0] rd_addr;
	logic disp_sel;
	logic clr_wr;
	logic [15:0] rd_data [2];
	logic rd_sel;
	logic [1:0] nib_sel;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable <= 1'b0;
			pal <= 4'd0;
			scroll_x <= 16'd0;
			scroll_y <= 16'd0;
			map_base <= 16'd0;
			set_base <= 16'd0;
		end else if (cpu_wr.wr && cpu_wr.layer == MY_ID) begin
			case (cpu_wr.addr)
				3'd0: begin
					enable <= cpu_wr.data[0];
					pal <= cpu_wr.data[7:4];
				end
				3'd1: scroll_x <= cpu_wr.data;
				3'd2: scroll_y <= cpu_wr.data;
				3'd3: map_base <= cpu_wr.data;
				3'd4: set_base <= cpu_wr.data;
				default: ;
			endcase
		end
	end

	assign swap = pos.line_start && enable;
	assign vy = scroll_y + {6'd0, pos.render_y};	// Map line in pixels

	// Byte index of the map entry, map is 128 tiles wide
	assign map_idx = {map_base, 1'b0} + {3'd0, vy[10:4], col};
	// Tile base plus tile*64 plus row*4 plus word
	assign tile_addr = set_base + {2'd0, tile, vy[3:0], word_cnt};

	// Skipped tiles are filled with zero words without a fetch
	assign fetch_wr = !swap && ((state == S_TILE && tile == 8'hFF) ||
		(state == S_TILE_WAIT && mem_rsp.ack));
	assign fetch_data = (state == S_TILE_WAIT) ? mem_rsp.data : 16'h0000;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= S_IDLE;
			back_sel <= 1'b0;
			mem_req <= '0;
			col <= 7'd0;
			tile_cnt <= 3'd0;
			word_cnt <= 2'd0;
			wr_ptr <= '0;
			tile <= 8'd0;
		end else if (swap) begin
			back_sel <= ~back_sel;
			state <= S_START;
			col <= scroll_x[10:4];
			tile_cnt <= 3'd0;
			word_cnt <= 2'd0;
			wr_ptr <= '0;
			if (mem_rsp.ack)
				mem_req.req <= 1'b0;
		end else begin
			case (state)
				S_START:
					if (!mem_req.req || mem_rsp.ack) begin
						mem_req.req <= 1'b0;
						state <= S_MAP;
					end
				S_MAP: begin
					mem_req.req <= 1'b1;
					mem_req.addr <= map_idx[16:1];
					state <= S_MAP_WAIT;
				end
				S_MAP_WAIT:
					if (mem_rsp.ack) begin
						mem_req.req <= 1'b0;
						tile <= col[0] ? mem_rsp.data[15:8] : mem_rsp.data[7:0];	// Low byte first
						word_cnt <= 2'd0;
						state <= S_TILE;
					end
				S_TILE:
					if (tile != 8'hFF) begin
						mem_req.req <= 1'b1;
						mem_req.addr <= tile_addr;
						state <= S_TILE_WAIT;
					end
				S_TILE_WAIT:
					if (mem_rsp.ack) begin
						mem_req.req <= 1'b0;
						state <= S_TILE;
					end
				default: state <= S_IDLE;
			endcase

			if (fetch_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
				word_cnt <= word_cnt + 1'b1;
				if (word_cnt == 2'd3) begin	// Tile done
					col <= col + 1'b1;
					tile_cnt <= tile_cnt + 1'b1;
					state <= (tile_cnt == LAST_TILE[2:0]) ? S_IDLE : S_MAP;
				end
			end
		end
	end

	assign px = pos.x + {6'd0, scroll_x[3:0]};
	assign rd_addr = px[`LINE_AW+1:2];
	// New display buffer is visible already in the swap cycle
	assign disp_sel = swap ? back_sel : ~back_sel;
	assign clr_wr = pos.active && (px[1:0] == 2'b11);	// Last pixel of the word

	for (genvar b = 0; b < 2; b++) begin : g_buf
		logic is_disp;

		assign is_disp = (disp_sel == 1'(b));

		scanline_ram u_ram (
			.CLK     (CLK),
			.rd_addr (rd_addr),
			.rd_data (rd_data[b]),
			.wr_addr (is_disp ? rd_addr : wr_ptr),
			.wr_data (is_disp ? 16'h0000 : fetch_data),
			.wr      (is_disp ? clr_wr : fetch_wr)
		);
	end

	always_ff @(posedge CLK) begin
		rd_sel <= disp_sel;
		nib_sel <= px[1:0];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			color <= 8'h00;
		else
			color <= enable ? {pal, rd_data[rd_sel][{nib_sel, 2'b00} +: 4]} : 8'h00;
	end

	assert property (@(posedge CLK) disable iff (!RSTb) mem_rsp.ack |-> mem_req.req)
		else $error("bg_layer %0d: memory ack without a request", LAYER_ID);

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`default_nettype none
`include "gfx_macros.svh"

module mem_arbiter (
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::mem_req_t [`NUM_LAYERS-1:0] reqs,
	output gfx_pkg::mem_rsp_t [`NUM_LAYERS-1:0] rsps,
	output gfx_pkg::mem_req_t mem_out,
	input wire gfx_pkg::mem_rsp_t mem_in
);
	logic [`LAYER_W-1:0] owner;
	logic busy;
	logic [`LAYER_W-1:0] pick;
	logic found;
	logic [`NUM_LAYERS-1:0] acks;

	// Round robin search starting after the last owner
	always_comb begin
		int cand;
		pick = owner;
		found = 1'b0;
		for (int k = 1; k <= `NUM_LAYERS; k++) begin
			cand = (int'(owner) + k) % `NUM_LAYERS;
			if (!found && reqs[cand].req) begin
				pick = cand[`LAYER_W-1:0];
				found = 1'b1;
			end
		end
	end

	always_comb begin
		mem_out = busy ? reqs[owner] : '0;
		for (int i = 0; i < `NUM_LAYERS; i++) begin
			acks[i] = busy && (owner == i[`LAYER_W-1:0]) && mem_in.ack;
			rsps[i].ack = acks[i];
			rsps[i].data = (owner == i[`LAYER_W-1:0]) ? mem_in.data : '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner <= '0;
			busy <= 1'b0;
		end else if (busy) begin
			if (mem_in.ack)
				busy <= 1'b0;	// Free again next cycle
		end else if (found) begin
			owner <= pick;
			busy <= 1'b1;
		end
	end

	assert property (@(posedge CLK) disable iff (!RSTb) busy |-> reqs[owner].req)
		else $error("mem_arbiter: port owner dropped its request before the ack");

	assert property (@(posedge CLK) disable iff (!RSTb) mem_in.ack |-> mem_out.req)
		else $error("mem_arbiter: memory ack without a request");

endmodule

`default_nettype wire

// File: src/layer_mixer.sv
`default_nettype none
`include "gfx_macros.svh"

module layer_mixer (
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::vid_pos_t pos,
	input wire gfx_pkg::color_t [`NUM_LAYERS-1:0] colors,
	output gfx_pkg::color_t pix_color,
	output logic pix_valid
);
	import gfx_pkg::*;

	logic [1:0] act_q;	// Matches the layer read-out latency
	color_t pick;

	// Lowest numbered opaque layer wins
	always_comb begin
		pick = '0;
		for (int i = `NUM_LAYERS - 1; i >= 0; i--)
			if (colors[i][3:0] != 4'd0)
				pick = colors[i];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			act_q <= 2'b00;
			pix_color <= '0;
			pix_valid <= 1'b0;
		end else begin
			act_q <= {act_q[0], pos.active};
			pix_valid <= act_q[1];
			pix_color <= act_q[1] ? pick : '0;
		end
	end

endmodule

`default_nettype wire

// File: src/tile_gfx_top.sv
`default_nettype none
`include "gfx_macros.svh"

module tile_gfx_top (
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::reg_wr_t cpu_wr,
	output wire gfx_pkg::mem_req_t mem_out,
	input wire gfx_pkg::mem_rsp_t mem_in,
	output wire gfx_pkg::color_t pix_color,
	output wire pix_valid,
	output wire frame_start
);
	import gfx_pkg::*;

	vid_pos_t pos;
	mem_req_t [`NUM_LAYERS-1:0] layer_req;
	mem_rsp_t [`NUM_LAYERS-1:0] layer_rsp;
	color_t [`NUM_LAYERS-1:0] layer_color;

	video_timing u_timing (
		.CLK  (CLK),
		.RSTb (RSTb),
		.pos  (pos)
	);

	for (genvar g = 0; g < `NUM_LAYERS; g++) begin : g_layer
		bg_layer #(
			.LAYER_ID (g)
		) u_layer (
			.CLK     (CLK),
			.RSTb    (RSTb),
			.cpu_wr  (cpu_wr),
			.pos     (pos),
			.mem_req (layer_req[g]),
			.mem_rsp (layer_rsp[g]),
			.color   (layer_color[g])
		);
	end

	mem_arbiter u_arbiter (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.reqs    (layer_req),
		.rsps    (layer_rsp),
		.mem_out (mem_out),
		.mem_in  (mem_in)
	);

	layer_mixer u_mixer (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.pos       (pos),
		.colors    (layer_color),
		.pix_color (pix_color),
		.pix_valid (pix_valid)
	);

	assign frame_start = pos.frame_start;

endmodule

`default_nettype wire

// File: tb/tile_gfx_tb.sv
`default_nettype none
`include "gfx_macros.svh"

module tile_gfx_tb;
	import gfx_pkg::*;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int NUM_FRAMES = 6;
	localparam int PIX_PER_FRAME = `H_ACTIVE * `V_ACTIVE;
	localparam int MAX_CYCLES = NUM_FRAMES * FRAME_CYCLES * 5 / 4;	// A quarter to spare

	logic CLK;
	logic RSTb;
	reg_wr_t cpu_wr;
	mem_req_t mem_out;
	mem_rsp_t mem_in;
	color_t pix_color;
	logic pix_valid;
	logic frame_start;

	integer seed = 32'hddd8_0c67;
	logic [15:0] mem [0:65535];	// Tile memory
	logic [15:0] rnd [16];	// Register values drawn up front

	// Register copies for the reference renderer
	logic lr_en [`NUM_LAYERS];
	logic [3:0] lr_pal [`NUM_LAYERS];
	logic [15:0] lr_sx [`NUM_LAYERS];
	logic [15:0] lr_sy [`NUM_LAYERS];
	logic [15:0] lr_map [`NUM_LAYERS];
	logic [15:0] lr_set [`NUM_LAYERS];

	int cycles = 0;
	int frame_idx = -1;
	int pix_cnt = 0;
	int chk_from = 0;
	int checked = 0;
	int errors = 0;
	int wait_left = 0;
	logic pending = 1'b0;
	logic [15:0] held_addr;
	color_t ex;
	int frame_cyc = 0;	// Cycles since the last frame strobe
	int pos_cyc;
	logic exp_valid;

	tile_gfx_top UUT (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.cpu_wr      (cpu_wr),
		.mem_out     (mem_out),
		.mem_in      (mem_in),
		.pix_color   (pix_color),
		.pix_valid   (pix_valid),
		.frame_start (frame_start)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	// Pixel nibble of one layer at map coordinates
	function automatic logic [3:0] layer_nibble(input int l, input int sx, input int sy);
		logic [16:0] byte_idx;
		logic [15:0] data;
		logic [15:0] addr;
		logic [7:0] tile;
		byte_idx = {lr_map[l], 1'b0} + 17'((sy / 16) * 128 + sx / 16);
		data = mem[byte_idx[16:1]];
		tile = byte_idx[0] ? data[15:8] : data[7:0];	// Low byte first
		if (tile == 8'hFF)
			return 4'd0;
		addr = lr_set[l] + 16'(tile * 64 + (sy % 16) * 4 + (sx % 16) / 4);
		data = mem[addr];
		return data[(sx % 4) * 4 +: 4];	// Leftmost pixel in the low nibble
	endfunction

	function automatic color_t expected_pixel(input int x, input int y);
		color_t result;
		logic [3:0] nib;
		result = 8'h00;
		// Walk down so layer 0 wins last
		for (int l = `NUM_LAYERS - 1; l >= 0; l--) begin
			if (lr_en[l]) begin
				nib = layer_nibble(l, (x + lr_sx[l]) % 2048, (y + lr_sy[l]) % 2048);
				if (nib != 4'd0)
					result = {lr_pal[l], nib};
			end
		end
		return result;
	endfunction

	task automatic write_reg(input int layer, input logic [2:0] addr, input logic [15:0] data);
		@(negedge CLK);
		cpu_wr.wr = 1'b1;
		cpu_wr.layer = layer[`LAYER_W-1:0];
		cpu_wr.addr = addr;
		cpu_wr.data = data;
		@(negedge CLK);
		cpu_wr = '0;
		case (addr)
			3'd0: begin
				lr_en[layer] = data[0];
				lr_pal[layer] = data[7:4];
			end
			3'd1: lr_sx[layer] = data;
			3'd2: lr_sy[layer] = data;
			3'd3: lr_map[layer] = data;
			3'd4: lr_set[layer] = data;
			default: ;	// Unused address has no effect
		endcase
		chk_from = frame_idx + 1;
	endtask

	// Returns once every pixel of frame f has come out
	task automatic wait_frame_shown(input int f);
		do
			@(posedge CLK);
		while (frame_idx != f || pix_cnt < PIX_PER_FRAME);
	endtask

	// Memory model acking after 0 to 2 wait cycles
	always @(negedge CLK) begin
		if (!RSTb || mem_in.ack) begin
			mem_in = '0;
			if (!RSTb)
				pending = 1'b0;
		end else if (mem_out.req) begin
			if (!pending) begin
				pending = 1'b1;
				held_addr = mem_out.addr;
				wait_left = $unsigned($random(seed)) % 3;
			end
			assert (mem_out.addr == held_addr) else begin
				errors++;
				$display("Memory address changed while a request was waiting at %0t", $time);
			end
			if (wait_left == 0) begin
				mem_in.ack = 1'b1;
				mem_in.data = mem[mem_out.addr];
				pending = 1'b0;
			end else
				wait_left--;
		end
	end

	// Output monitor
	always @(negedge CLK) begin
		if (RSTb) begin
			if (frame_start) begin
				frame_idx++;
				pix_cnt = 0;
				frame_cyc = 0;
			end
			// Pixels leave the pipeline 3 cycles after their position
			pos_cyc = frame_cyc - 3;
			exp_valid = (frame_idx >= 0) && (pos_cyc >= 0) &&
				(pos_cyc % `H_TOTAL < `H_ACTIVE) && (pos_cyc / `H_TOTAL < `V_ACTIVE);
			assert (pix_valid == exp_valid) else begin
				errors++;
				$display("Fail at %0t: pix_valid expected %b, got %b", $time, exp_valid, pix_valid);
			end
			assert (pix_valid || pix_color == 8'h00) else begin
				errors++;
				$display("Fail at %0t: pix_color expected 00, got %h", $time, pix_color);
			end
			if (pix_valid) begin
				ex = expected_pixel(pix_cnt % `H_ACTIVE, pix_cnt / `H_ACTIVE);
				if (frame_idx >= chk_from) begin
					checked++;
					assert (pix_color == ex) else begin
						errors++;
						$display("Fail at %0t: pix_color expected %h, got %h", $time, ex, pix_color);
					end
				end
				pix_cnt++;
			end
			frame_cyc++;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 16'($random(seed));
			if (($random(seed) & 7) == 0)
				mem[i][7:0] = 8'hFF;	// Skipped tiles
			if (($random(seed) & 7) == 0)
				mem[i][15:8] = 8'hFF;
		end
		for (int i = 0; i < 16; i++)
			rnd[i] = 16'($random(seed));
		for (int l = 0; l < `NUM_LAYERS; l++) begin
			lr_en[l] = 1'b0;
			lr_pal[l] = 4'd0;
			lr_sx[l] = 16'd0;
			lr_sy[l] = 16'd0;
			lr_map[l] = 16'd0;
			lr_set[l] = 16'd0;
		end
		cpu_wr = '0;
		mem_in = '0;
		RSTb = 1'b0;
		repeat (3) @(negedge CLK);
		RSTb = 1'b1;

		wait_frame_shown(0);	// Both layers off
		write_reg(0, 3'd3, rnd[0]);
		write_reg(0, 3'd4, rnd[1]);
		write_reg(0, 3'd1, 16'd0);
		write_reg(0, 3'd2, 16'd0);
		write_reg(0, 3'd0, {8'h00, rnd[2][7:4], 4'h1});

		wait_frame_shown(1);	// Layer 0 alone
		write_reg(0, 3'd1, rnd[3]);
		write_reg(0, 3'd2, rnd[4]);
		write_reg(1, 3'd7, rnd[5]);

		wait_frame_shown(2);	// Scrolled
		write_reg(1, 3'd3, rnd[6]);
		write_reg(1, 3'd4, rnd[7]);
		write_reg(1, 3'd1, rnd[8]);
		write_reg(1, 3'd2, rnd[9]);
		write_reg(1, 3'd0, {8'h00, rnd[10][7:4], 4'h1});

		wait_frame_shown(3);	// Both layers
		write_reg(0, 3'd1, rnd[11]);
		write_reg(1, 3'd2, rnd[12]);

		wait_frame_shown(4);
		write_reg(0, 3'd0, {8'h00, rnd[2][7:4], 4'h0});

		wait_frame_shown(5);	// Layer 1 only
		$display("Checked %0d pixels, %0d errors", checked, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
src/gfx_pkg.sv
src/video_timing.sv
src/scanline_ram.sv
src/bg_layer.sv
src/mem_arbiter.sv
src/layer_mixer.sv
src/tile_gfx_top.sv
tb/tile_gfx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tile engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tile_gfx_tb -Mdir obj_dir -o tile_gfx_sim; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tile_gfx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "No pass line in $LOG"
	exit 1
fi

exit 0
